// ==== div_pkg.sv ====
package div_pkg;

    localparam int XLEN = 64;
    localparam int WLEN = 32;

    // quotient bits per op width.
    localparam int ITER64 = 64;
    localparam int ITER32 = 32;

    // accept edge to first done-high edge.
    localparam int LAT64 = ITER64 + 2;
    localparam int LAT32 = ITER32 + 2;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [WLEN-1:0]   word_t;
    typedef logic [2*XLEN-1:0] acc_t;  // partial remainder and quotient.
    typedef logic [6:0]        cnt_t;

    typedef enum logic [2:0] {
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW
    } div_op_t;

    typedef struct packed {
        div_op_t op;
        xlen_t   dividend;
        xlen_t   divisor;
    } div_req_t;

    typedef struct packed {
        xlen_t dividend_mag;
        xlen_t divisor_mag;
        logic  is_word;
    } core_in_t;

    typedef struct packed {
        xlen_t quotient_mag;
        xlen_t remainder_mag;
    } core_out_t;

    typedef struct packed {
        logic  is_word;
        logic  want_rem;
        logic  neg_quot;
        logic  neg_rem;
        logic  div_zero;
        logic  overflow;
        xlen_t orig_dividend;  // zero-extended for word ops.
    } div_meta_t;

endpackage

// ==== div_prep.sv ====
`timescale 1ns/1ns

module div_prep (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_in,
    input  div_pkg::div_req_t   req,
    input  logic                done,
    output logic                busy,
    output logic                start,
    output div_pkg::core_in_t   core_in,
    output div_pkg::div_meta_t  meta
);
    import div_pkg::*;

    logic  is_word;
    logic  is_signed;
    logic  want_rem;
    logic  busy_q;
    logic  accept;
    word_t dvd_w;
    word_t dvs_w;
    word_t dvd_neg_w;
    word_t dvs_neg_w;
    xlen_t dvd_neg;
    xlen_t dvs_neg;
    logic  dvd_sign;
    logic  dvs_sign;
    xlen_t dvd_mag;
    xlen_t dvs_mag;
    xlen_t dvd_trunc;
    logic  dvs_zero;
    logic  min_by_neg1;

    always_comb begin
        is_word   = 1'b0;
        is_signed = 1'b0;
        want_rem  = 1'b0;
        case (req.op)
            OP_DIV:   is_signed = 1'b1;
            OP_DIVU:  ;
            OP_REM:   {is_signed, want_rem} = 2'b11;
            OP_REMU:  want_rem = 1'b1;
            OP_DIVW:  {is_word, is_signed} = 2'b11;
            OP_DIVUW: is_word = 1'b1;
            OP_REMW:  {is_word, is_signed, want_rem} = 3'b111;
            OP_REMUW: {is_word, want_rem} = 2'b11;
        endcase
    end

    assign dvd_w     = req.dividend[WLEN-1:0];
    assign dvs_w     = req.divisor[WLEN-1:0];
    assign dvd_neg_w = -dvd_w;
    assign dvs_neg_w = -dvs_w;
    assign dvd_neg   = -req.dividend;
    assign dvs_neg   = -req.divisor;

    always_comb begin
        if (is_word) begin
            dvd_sign    = is_signed & dvd_w[WLEN-1];
            dvs_sign    = is_signed & dvs_w[WLEN-1];
            dvd_mag     = {{(XLEN-WLEN){1'b0}}, dvd_sign ? dvd_neg_w : dvd_w};
            dvs_mag     = {{(XLEN-WLEN){1'b0}}, dvs_sign ? dvs_neg_w : dvs_w};
            dvd_trunc   = {{(XLEN-WLEN){1'b0}}, dvd_w};
            dvs_zero    = (dvs_w == '0);
            min_by_neg1 = (dvd_w == {1'b1, {(WLEN-1){1'b0}}}) && (dvs_w == '1);
        end else begin
            dvd_sign    = is_signed & req.dividend[XLEN-1];
            dvs_sign    = is_signed & req.divisor[XLEN-1];
            dvd_mag     = dvd_sign ? dvd_neg : req.dividend;
            dvs_mag     = dvs_sign ? dvs_neg : req.divisor;
            dvd_trunc   = req.dividend;
            dvs_zero    = (req.divisor == '0);
            min_by_neg1 = (req.dividend == {1'b1, {(XLEN-1){1'b0}}}) && (req.divisor == '1);
        end
    end

    assign accept = valid_in & ~busy;
    assign busy   = busy_q & ~done;  // free again in the done cycle.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            start  <= 1'b0;
        end else begin
            start <= accept;
            if (accept)
                busy_q <= 1'b1;
            else if (done)
                busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            core_in.dividend_mag <= dvd_mag;
            core_in.divisor_mag  <= dvs_mag;
            core_in.is_word      <= is_word;
            meta.is_word         <= is_word;
            meta.want_rem        <= want_rem;
            meta.neg_quot        <= dvd_sign ^ dvs_sign;
            meta.neg_rem         <= dvd_sign;
            meta.div_zero        <= dvs_zero;
            meta.overflow        <= is_signed & min_by_neg1;
            meta.orig_dividend   <= dvd_trunc;
        end
    end

endmodule

// ==== div_core.sv ====
`timescale 1ns/1ns

module div_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  div_pkg::core_in_t   core_in,
    output logic                core_done,
    output div_pkg::core_out_t  core_out
);
    import div_pkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } core_state_t;

    core_state_t   state;
    cnt_t          cnt;
    acc_t          acc;
    acc_t          acc_shift;
    acc_t          acc_next;
    xlen_t         divisor;
    logic [XLEN:0] trial;
    logic          last;

    assign acc_shift = {acc[2*XLEN-2:0], 1'b0};
    assign trial     = {1'b0, acc_shift[2*XLEN-1:XLEN]} - {1'b0, divisor};
    assign last      = (cnt == cnt_t'(1));

    // keep the difference and shift in a one when nothing borrows.
    always_comb begin
        if (!trial[XLEN])
            acc_next = {trial[XLEN-1:0], acc_shift[XLEN-1:1], 1'b1};
        else
            acc_next = acc_shift;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            cnt       <= '0;
            core_done <= 1'b0;
        end else begin
            core_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        cnt   <= core_in.is_word ? cnt_t'(ITER32) : cnt_t'(ITER64);
                    end
                end
                RUN: begin
                    cnt <= cnt - cnt_t'(1);
                    if (last) begin
                        state     <= IDLE;
                        core_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // word dividend sits at the top of the low half so 32 shifts suffice.
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            if (core_in.is_word) begin
                acc     <= {{XLEN{1'b0}}, core_in.dividend_mag[WLEN-1:0], {WLEN{1'b0}}};
                divisor <= {{(XLEN-WLEN){1'b0}}, core_in.divisor_mag[WLEN-1:0]};
            end else begin
                acc     <= {{XLEN{1'b0}}, core_in.dividend_mag};
                divisor <= core_in.divisor_mag;
            end
        end else if (state == RUN) begin
            acc <= acc_next;
            if (last) begin
                core_out.quotient_mag  <= acc_next[XLEN-1:0];
                core_out.remainder_mag <= acc_next[2*XLEN-1:XLEN];
            end
        end
    end

endmodule

// ==== div_post.sv ====
`timescale 1ns/1ns

module div_post (
    input  logic                clk,
    input  logic                rst,
    input  logic                core_done,
    input  div_pkg::core_out_t  core_out,
    input  div_pkg::div_meta_t  meta,
    output logic                done,
    output div_pkg::xlen_t      result
);
    import div_pkg::*;

    xlen_t quot;
    xlen_t rem;
    xlen_t sel;
    word_t sel_w;
    xlen_t res_next;

    always_comb begin
        quot = meta.neg_quot ? -core_out.quotient_mag : core_out.quotient_mag;
        rem  = meta.neg_rem ? -core_out.remainder_mag : core_out.remainder_mag;

        // architectural answers override the iterated ones.
        if (meta.div_zero) begin
            quot = '1;
            rem  = meta.orig_dividend;
        end else if (meta.overflow) begin
            quot = meta.orig_dividend;
            rem  = '0;
        end

        sel = meta.want_rem ? rem : quot;
    end

    assign sel_w = sel[WLEN-1:0];

    always_comb begin
        if (meta.is_word)
            res_next = {{(XLEN-WLEN){sel_w[WLEN-1]}}, sel_w};  // sign-extend bit 31.
        else
            res_next = sel;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= core_done;
            if (core_done)
                result <= res_next;  // held until the next done.
        end
    end

endmodule

// ==== div_unit.sv ====
`timescale 1ns/1ns

module div_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_in,
    input  div_pkg::div_req_t  req,
    output logic               busy,
    output logic               done,
    output div_pkg::xlen_t     result
);
    import div_pkg::*;

    logic      start;
    logic      core_done;
    core_in_t  core_in;
    core_out_t core_out;
    div_meta_t meta;

    div_prep u_prep (
        .clk      (clk),
        .rst      (rst),
        .valid_in (valid_in),
        .req      (req),
        .done     (done),
        .busy     (busy),
        .start    (start),
        .core_in  (core_in),
        .meta     (meta)
    );

    div_core u_core (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .core_in   (core_in),
        .core_done (core_done),
        .core_out  (core_out)
    );

    // done loops back to prep to release busy.
    div_post u_post (
        .clk       (clk),
        .rst       (rst),
        .core_done (core_done),
        .core_out  (core_out),
        .meta      (meta),
        .done      (done),
        .result    (result)
    );

endmodule

// ==== div_unit_sva.sv ====
`timescale 1ns/1ns

module div_unit_sva (
    input logic             clk,
    input logic             rst,
    input logic             valid_in,
    input logic             busy,
    input logic             start,
    input logic             done,
    input div_pkg::div_op_t op
);
    import div_pkg::*;

    logic accept;
    logic acc64;
    logic acc32;

    assign accept = valid_in & ~busy;
    assign acc32  = accept & (op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW});
    assign acc64  = accept & ~acc32;

    start_after_accept: assert property (@(posedge clk) disable iff (rst)
        accept |=> start)
        else $error("start missing one cycle after an accepted request");

    // busy covers the request right up to its done.
    busy_until_done: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(busy))
        else $error("done without a request in flight");

    // done is sampled high one tick after the edge at E0+LAT.
    done_after_lat64: assert property (@(posedge clk) disable iff (rst)
        $past(acc64, LAT64 + 1) |-> $rose(done))
        else $error("done did not rise LAT64 cycles after a 64-bit request");

    done_after_lat32: assert property (@(posedge clk) disable iff (rst)
        $past(acc32, LAT32 + 1) |-> $rose(done))
        else $error("done did not rise LAT32 cycles after a word request");

    done_only_at_lat: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(acc64, LAT64 + 1) || $past(acc32, LAT32 + 1))
        else $error("done rose with no request accepted at the right distance");

endmodule

bind div_unit div_unit_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .valid_in (valid_in),
    .busy     (busy),
    .start    (start),
    .done     (done),
    .op       (req.op)
);

// ==== div_unit_tb.sv ====
`timescale 1ns/1ns

module div_unit_tb;
    import div_pkg::*;

    localparam int    N_RAND64 = 40;
    localparam int    N_RANDW  = 40;
    localparam int    N_REQS   = N_RAND64 + N_RANDW + 12 + 3;
    localparam int    LIMIT    = N_REQS * (LAT64 + 4) + 200;
    localparam xlen_t MIN64    = {1'b1, {(XLEN-1){1'b0}}};
    localparam word_t MIN32    = {1'b1, {(WLEN-1){1'b0}}};

    logic     clk;
    logic     rst;
    logic     valid_in;
    div_req_t req;
    logic     busy;
    logic     done;
    xlen_t    result;

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     errs_before;
    int     cycle_cnt;

    div_unit u_dut (
        .clk      (clk),
        .rst      (rst),
        .valid_in (valid_in),
        .req      (req),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic is_word_op(input div_op_t op);
        return op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    endfunction

    // riscv m-extension answers with the special cases first.
    function automatic xlen_t riscv_div(input div_op_t op, input xlen_t a, input xlen_t b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [WLEN-1:0] swa;
        logic signed [WLEN-1:0] swb;
        word_t wa;
        word_t wb;
        word_t wr;
        xlen_t r;
        logic  is_div;
        sa     = a;
        sb     = b;
        wa     = a[WLEN-1:0];
        wb     = b[WLEN-1:0];
        swa    = wa;
        swb    = wb;
        r      = '0;
        wr     = '0;
        is_div = op inside {OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW};
        if (is_word_op(op)) begin
            if (wb == '0) begin
                wr = is_div ? '1 : wa;
            end else if (op inside {OP_DIVW, OP_REMW} && wa == MIN32 && wb == '1) begin
                wr = is_div ? wa : '0;
            end else begin
                case (op)
                    OP_DIVW:  wr = swa / swb;
                    OP_DIVUW: wr = wa / wb;
                    OP_REMW:  wr = swa % swb;
                    default:  wr = wa % wb;
                endcase
            end
            r = {{(XLEN-WLEN){wr[WLEN-1]}}, wr};  // sign-extend bit 31.
        end else if (b == '0) begin
            r = is_div ? '1 : a;
        end else if (op inside {OP_DIV, OP_REM} && a == MIN64 && b == '1) begin
            r = is_div ? a : '0;
        end else begin
            case (op)
                OP_DIV:  r = sa / sb;
                OP_DIVU: r = a / b;
                OP_REM:  r = sa % sb;
                default: r = a % b;
            endcase
        end
        return r;
    endfunction

    // called just after a rising edge.
    task automatic strobe(input div_req_t r);
        valid_in = 1'b1;
        req      = r;
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    task automatic wait_done(output int cyc);
        cyc = 0;
        do begin
            @(posedge clk);
            #1;
            cyc++;
        end while (!done && cyc < LAT64 + 8);
    endtask

    task automatic check_req(input string name, input div_req_t r);
        xlen_t exp;
        int    lat;
        int    cyc;
        exp = riscv_div(r.op, r.dividend, r.divisor);
        lat = is_word_op(r.op) ? LAT32 : LAT64;
        strobe(r);
        wait_done(cyc);
        checks++;
        if (!done) begin
            $display("%s: no done within %0d cycles of the request", name, cyc);
            errors++;
        end else begin
            if (cyc != lat) begin
                $display("ERR %s latency expected %0d actual %0d", name, lat, cyc);
                errors++;
            end
            if (result !== exp) begin
                $display("ERR %s expected %h actual %h", name, exp, result);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name, input int nreq);
        tests_run++;
        if (errors != errs_before)
            tests_failed++;
        $display("test %s: %0d requests, %0d errors", name, nreq, errors - errs_before);
        errs_before = errors;
    endtask

    initial begin
        div_req_t   r;
        div_req_t   ra;
        logic [31:0] bits;
        word_t      w;
        xlen_t      exp;
        int         cyc;
        int         extra;
        clk          = 1'b0;
        rst          = 1'b1;
        valid_in     = 1'b0;
        req          = '0;
        seed         = 32'h4793_52d0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        errs_before  = 0;
        cycle_cnt    = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle outputs before any request.
        repeat (8) begin
            @(posedge clk);
            #1;
            checks++;
            if (busy || done) begin
                $display("reset_idle: busy or done high before any request");
                errors++;
            end
            if (result !== '0) begin
                $display("ERR reset_idle expected %h actual %h", xlen_t'(0), result);
                errors++;
            end
        end
        end_test("reset_idle", 0);

        for (int i = 0; i < N_RAND64; i++) begin
            bits       = $random(seed);
            r.op       = div_op_t'({1'b0, bits[1:0]});
            r.dividend = rand64();
            r.divisor  = rand64() >> bits[7:2];
            if (bits[8])
                r.divisor = -r.divisor;
            check_req("rand64", r);
        end
        end_test("rand64", N_RAND64);

        for (int i = 0; i < N_RANDW; i++) begin
            bits       = $random(seed);
            r.op       = div_op_t'({1'b1, bits[1:0]});
            r.dividend = rand64();  // upper half is garbage.
            w          = $random(seed);
            w          = w >> bits[6:2];
            if (bits[7])
                w = -w;
            r.divisor = {$random(seed), w};
            check_req("rand_word", r);
        end
        end_test("rand_word", N_RANDW);

        for (int k = 0; k < 8; k++) begin
            r.op       = div_op_t'(3'(k));
            r.dividend = rand64();
            if (k >= 4)
                r.divisor = {$random(seed), word_t'(0)};
            else
                r.divisor = '0;
            check_req("special", r);
        end
        r.dividend = MIN64;
        r.divisor  = '1;
        r.op       = OP_DIV;
        check_req("special", r);
        r.op = OP_REM;
        check_req("special", r);
        r.dividend = {$random(seed), MIN32};
        r.divisor  = {$random(seed), 32'hffff_ffff};
        r.op       = OP_DIVW;
        check_req("special", r);
        r.op = OP_REMW;
        check_req("special", r);
        end_test("special", 12);

        ra.op       = OP_DIV;
        ra.dividend = rand64();
        ra.divisor  = rand64() >> 20;
        exp         = riscv_div(ra.op, ra.dividend, ra.divisor);
        strobe(ra);
        repeat (5) @(posedge clk);
        #1;
        checks++;
        if (!busy) begin
            $display("busy_strobe: busy low while the first request was running");
            errors++;
        end
        r.op       = OP_REMU;
        r.dividend = rand64();
        r.divisor  = 64'd7;
        strobe(r);  // dropped while the unit is busy.
        wait_done(cyc);
        cyc = cyc + 6;
        checks++;
        if (!done) begin
            $display("busy_strobe: first request never finished");
            errors++;
        end else begin
            if (cyc != LAT64) begin
                $display("ERR busy_strobe latency expected %0d actual %0d", LAT64, cyc);
                errors++;
            end
            if (result !== exp) begin
                $display("ERR busy_strobe expected %h actual %h", exp, result);
                errors++;
            end
        end
        r.op = OP_DIVW;
        check_req("busy_strobe", r);  // strobed in the done cycle.
        extra = 0;
        repeat (LAT64 + 2) begin
            @(posedge clk);
            #1;
            if (done)
                extra++;
        end
        if (extra != 0) begin
            $display("busy_strobe: done pulsed again with no request pending");
            errors++;
        end
        end_test("busy_strobe", 3);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
div_pkg.sv
div_prep.sv
div_core.sv
div_post.sv
div_unit.sv
div_unit_sva.sv
div_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the divide unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module div_unit_tb -f verilog.f -o div_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/div_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0
